//--- bench/as5600_model.sv
// ----------------------------------------------------------
// AS5600 I2C target model
// Checks the raw-angle read sequence and returns a set angle
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module as5600_model (
    input  logic                    PHASE1,
    input  logic                    scl,
    inout  wire                     sda,
    input  motor_angle_pkg::angle_t angle,
    output logic                    protocol_ok,
    output int                      start_count,
    output int                      stop_count
);
    import motor_angle_pkg::*;

    logic      prev_scl  = 1'b1;
    logic      prev_sda  = 1'b1;
    logic      cur_sda   = 1'b1;
    logic      drive_low = 1'b0;
    logic      in_txn    = 1'b0;
    int        frame_bit = 0;   // 0..7 data, 8 acknowledge
    int        byte_num  = 0;   // 0 dev write, 1 reg, 2 dev read, 3 hi, 4 lo
    i2c_byte_t rx_shift  = '0;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial begin
        protocol_ok = 1'b1;
        start_count = 0;
        stop_count  = 0;
    end

    function automatic i2c_byte_t expected_byte(int n);
        case (n)
            0:       return DEV_WRITE_BYTE;
            1:       return RAW_ANGLE_REG;
            default: return DEV_READ_BYTE;
        endcase
    endfunction

    function automatic logic read_bit(int n, int b);
        i2c_byte_t d;
        d = (n == 3) ? {4'h0, angle[11:8]} : angle[7:0];
        return d[7 - b];
    endfunction

    task automatic report_error(string msg);
        $display("FAIL @%0t: %s", $time, msg);
        protocol_ok = 1'b0;
    endtask

    // Oversampled in mid cycle, so SCL and SDA are settled
    always @(negedge PHASE1) begin
        cur_sda = (sda !== 1'b0);
        if (prev_scl && scl && prev_sda && !cur_sda) begin
            if (in_txn) begin
                if (byte_num != 2) report_error("repeated START out of place");
                byte_num = 2;
            end else begin
                byte_num = 0;
                start_count++;
            end
            in_txn    = 1'b1;
            frame_bit = 0;
            rx_shift  = '0;
        end else if (prev_scl && scl && !prev_sda && cur_sda) begin
            if (!in_txn || byte_num != 5) report_error("STOP before both data bytes");
            in_txn = 1'b0;
            stop_count++;
        end else if (!prev_scl && scl && in_txn) begin
            if (frame_bit < 8) begin
                rx_shift = {rx_shift[6:0], cur_sda};
            end else begin
                if (byte_num <= 2 && rx_shift != expected_byte(byte_num))
                    report_error($sformatf("byte %0d is %02h, expected %02h",
                                           byte_num, rx_shift, expected_byte(byte_num)));
                if (byte_num == 3 && cur_sda) report_error("master did not ACK high byte");
                if (byte_num == 4 && !cur_sda) report_error("master did not NACK low byte");
            end
            frame_bit++;
            if (frame_bit == 9) begin
                frame_bit = 0;
                byte_num++;
            end
        end else if (prev_scl && !scl) begin
            drive_low = 1'b0;  // Change SDA only while SCL is low
            if (in_txn && frame_bit == 8 && byte_num <= 2)
                drive_low = 1'b1;
            else if (in_txn && frame_bit < 8 && (byte_num == 3 || byte_num == 4))
                drive_low = !read_bit(byte_num, frame_bit);
        end
        prev_scl = scl;
        prev_sda = cur_sda;
    end

endmodule

`default_nettype wire

//--- bench/clock_gen.sv
// ----------------------------------------------------------
// Testbench clock and reset source
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic PHASE1,
    output logic reset_n
);
    localparam int HALF_PERIOD  = 4;   // 8 ns clock
    localparam int RESET_CYCLES = 10;

    initial begin
        PHASE1 = 1'b0;
        forever #HALF_PERIOD PHASE1 = ~PHASE1;
    end

    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge PHASE1);
        reset_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- bench/tb_motor_ctrl.sv
// ----------------------------------------------------------
// Motor angle loop testbench
// Random angle reads, error rule, PWM duty and enable drop
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_motor_ctrl;
    import motor_angle_pkg::*;

    localparam int TXN_CYCLES     = 196;
    localparam int NUM_ANGLES     = 8;
    localparam int PWM_PERIOD     = 4096;
    localparam int TIMEOUT_CYCLES = 40000;

    logic          PHASE1;
    logic          reset_n;
    logic          enable;
    angle_t        target_angle;
    logic          scl;
    tri1           sda;
    logic          pwm_out;
    logic          dir;
    angle_sample_t sample;
    angle_t        model_angle;
    logic          protocol_ok;
    int            start_count;
    int            stop_count;
    int            cycle_cnt = 0;
    angle_t        angles  [NUM_ANGLES + 1];
    angle_t        targets [NUM_ANGLES + 1];
    int            last_strobe;
    int            starts_seen;
    logic          exp_dir;
    int            exp_duty;

    clock_gen clk_i (.PHASE1(PHASE1), .reset_n(reset_n));

    motor_ctrl_top dut_i (
        .PHASE1       (PHASE1),
        .reset_n      (reset_n),
        .enable       (enable),
        .target_angle (target_angle),
        .scl          (scl),
        .sda          (sda),
        .pwm_out      (pwm_out),
        .dir          (dir),
        .sample       (sample)
    );

    as5600_model model_i (
        .PHASE1      (PHASE1),
        .scl         (scl),
        .sda         (sda),
        .angle       (model_angle),
        .protocol_ok (protocol_ok),
        .start_count (start_count),
        .stop_count  (stop_count)
    );

    task automatic stop_on_error(string line);
        $display("%s", line);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // Shortest signed error, deadband, doubled and saturated duty
    function automatic void expected_drive(input angle_t tgt, input angle_t ang,
                                           output logic d, output int duty);
        int diff;
        int mag;
        diff = (int'(tgt) - int'(ang) + 4096) % 4096;
        if (diff >= 2048) diff -= 4096;
        d   = (diff < 0);
        mag = (diff < 0) ? -diff : diff;
        if (mag < int'(DEADBAND)) duty = 0;
        else if (2 * mag > int'(DUTY_MAX)) duty = int'(DUTY_MAX);
        else duty = 2 * mag;
    endfunction

    task automatic check_idle_pins();
        assert (scl === 1'b1 && sda === 1'b1 && pwm_out === 1'b0 && dir === 1'b0 &&
                sample.sample_strobe === 1'b0)
        else stop_on_error($sformatf("FAIL @%0t: bus or outputs not idle", $time));
    endtask

    task automatic wait_strobe();
        do @(negedge PHASE1); while (!sample.sample_strobe);
    endtask

    // Pending duty reaches a whole period within one period, then count one period
    task automatic check_pwm_duty(input int duty, input logic d);
        int high_cnt;
        high_cnt = 0;
        repeat (PWM_PERIOD) @(negedge PHASE1);
        repeat (PWM_PERIOD) begin
            @(negedge PHASE1);
            if (pwm_out) high_cnt++;
        end
        assert (high_cnt == duty && dir == d)
        else stop_on_error($sformatf("FAIL @%0t: PWM high %0d cycles, expected %0d", $time,
                                     high_cnt, duty));
    endtask

    // Enable held only until the START shows, then the read and its drive
    task automatic single_read(input angle_t ang, input angle_t tgt);
        int   starts;
        logic d;
        int   duty;
        starts = start_count;
        @(posedge PHASE1);
        model_angle  <= ang;
        target_angle <= tgt;
        enable       <= 1'b1;
        do @(posedge PHASE1); while (start_count == starts);
        enable <= 1'b0;
        wait_strobe();
        assert (sample.sample_angle == ang)
        else stop_on_error($sformatf("FAIL @%0t: angle %0d, expected %0d", $time,
                                     sample.sample_angle, ang));
        expected_drive(tgt, ang, d, duty);
        @(negedge PHASE1);
        assert (dir == d)
        else stop_on_error($sformatf("FAIL @%0t: dir %0b, expected %0b", $time, dir, d));
        check_pwm_duty(duty, d);
    endtask

    strobe_single: assert property (@(posedge PHASE1) disable iff (!reset_n)
        sample.sample_strobe |=> !sample.sample_strobe)
    else stop_on_error($sformatf("FAIL @%0t: strobe longer than one cycle", $time));

    model_clean: assert property (@(posedge PHASE1) protocol_ok)
    else stop_on_error("The AS5600 model saw an I2C protocol error");

    always @(posedge PHASE1) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            stop_on_error($sformatf("Timeout: run went past %0d cycles", TIMEOUT_CYCLES));
    end

    initial begin
        void'($urandom(18));
        enable       = 1'b0;
        target_angle = '0;
        model_angle  = '0;
        for (int i = 0; i <= NUM_ANGLES; i++) begin
            angles[i]  = angle_t'($urandom % 4096);
            targets[i] = angle_t'($urandom % 4096);
        end
        angles[1]  = 12'd4090;                    // Wrap-around, positive error
        targets[1] = 12'd10;
        angles[2]  = 12'd10;                      // Wrap-around, negative error
        targets[2] = 12'd4090;
        targets[3] = angles[3] + 12'd3;           // Inside the deadband
        targets[4] = angles[4] + 12'd2048;        // Saturates
        targets[5] = angles[5] - 12'd5;
        targets[NUM_ANGLES] = angles[NUM_ANGLES] + 12'd300;

        while (reset_n !== 1'b1) begin
            @(negedge PHASE1);
            check_idle_pins();
        end
        repeat (300) begin
            @(negedge PHASE1);
            check_idle_pins();
            assert (start_count == 0)
            else stop_on_error($sformatf("FAIL @%0t: START while disabled", $time));
        end

        @(posedge PHASE1);
        model_angle  <= angles[0];
        target_angle <= targets[0];
        enable       <= 1'b1;

        for (int i = 0; i <= NUM_ANGLES; i++) begin
            wait_strobe();
            assert (sample.sample_angle == angles[i])
            else stop_on_error($sformatf("FAIL @%0t: angle %0d, expected %0d", $time,
                                         sample.sample_angle, angles[i]));
            if (i > 0) begin
                assert (cycle_cnt - last_strobe == TXN_CYCLES)
                else stop_on_error($sformatf("FAIL @%0t: strobe spacing %0d cycles", $time,
                                             cycle_cnt - last_strobe));
            end
            last_strobe = cycle_cnt;
            expected_drive(targets[i], angles[i], exp_dir, exp_duty);
            @(posedge PHASE1);
            if (i < NUM_ANGLES) begin
                model_angle  <= angles[i + 1];
                target_angle <= targets[i + 1];
            end
            @(negedge PHASE1);
            assert (dir == exp_dir)
            else stop_on_error($sformatf("FAIL @%0t: dir %0b, expected %0b", $time,
                                         dir, exp_dir));
            if (i == NUM_ANGLES - 1) begin
                repeat (100) @(posedge PHASE1);
                enable <= 1'b0;                   // Mid transaction
            end
        end

        starts_seen = start_count;
        repeat (300) begin
            @(negedge PHASE1);
            assert (start_count == starts_seen && !sample.sample_strobe)
            else stop_on_error($sformatf("FAIL @%0t: bus active after enable drop", $time));
        end

        check_pwm_duty(exp_duty, exp_dir);
        single_read(angles[3], targets[3]);       // No drive inside the deadband
        single_read(angles[4], targets[4]);       // Full drive

        assert (start_count == NUM_ANGLES + 3 && stop_count == start_count)
        else stop_on_error($sformatf("FAIL @%0t: %0d STARTs and %0d STOPs, expected %0d",
                                     $time, start_count, stop_count, NUM_ANGLES + 3));

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/angle_pwm_controller.sv
// ----------------------------------------------------------
// Angle error to PWM drive
// Shortest-path error, deadband and saturated duty per period
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module angle_pwm_controller (
    input  logic                           PHASE1,
    input  logic                           reset_n,
    input  motor_angle_pkg::angle_sample_t sample,
    input  motor_angle_pkg::angle_t        target_angle,
    output logic                           pwm_out,
    output logic                           dir      // 1 when the error is negative
);
    import motor_angle_pkg::*;

    duty_t      period_cnt;
    duty_t      duty_pend;
    duty_t      duty_act;
    angle_err_t err;
    angle_t     err_mag;
    duty_t      duty_calc;

    // Modulo 4096 difference is already the shortest way around
    assign err = angle_err_t'(target_angle - sample.sample_angle);

    // -2048 maps onto 2048 as an unsigned count
    assign err_mag = err[11] ? angle_t'(-err) : angle_t'(err);

    always_comb begin
        if (err_mag < DEADBAND) begin
            duty_calc = '0;
        end else if (err_mag[11]) begin
            duty_calc = DUTY_MAX;  // Twice 2048 no longer fits
        end else begin
            duty_calc = {err_mag[10:0], 1'b0};
        end
    end

    always_ff @(posedge PHASE1 or negedge reset_n) begin
        if (!reset_n) begin
            period_cnt <= '0;
            duty_pend  <= '0;
            duty_act   <= '0;
            dir        <= 1'b0;
        end else begin
            period_cnt <= period_cnt + 12'd1;

            if (sample.sample_strobe) begin
                dir       <= err[11];
                duty_pend <= duty_calc;  // Last strobe wins
            end

            // Counter about to wrap, new period starts with the pending duty
            if (&period_cnt) begin
                duty_act <= duty_pend;
            end
        end
    end

    assign pwm_out = (period_cnt < duty_act);

endmodule

`default_nettype wire

//--- hdl/encoder_i2c_reader.sv
// ----------------------------------------------------------
// AS5600 raw-angle reader
// I2C master repeating the 12-bit angle read while enabled
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module encoder_i2c_reader (
    input  logic                           PHASE1,
    input  logic                           reset_n,
    input  logic                           enable,   // Keep reading while high
    output logic                           scl,
    inout  wire                            sda,
    output motor_angle_pkg::angle_sample_t sample
);
    import motor_angle_pkg::*;

    localparam quarter_t LAST_QTR   = quarter_t'(QUARTERS_PER_BIT - 1);
    localparam quarter_t SAMPLE_QTR = quarter_t'(QUARTERS_PER_BIT - 2);

    quarter_t   quarter;
    bus_state_t state;
    bus_state_t next_state;
    logic [2:0] bit_cnt;
    logic       slot_end;
    logic       byte_done;
    logic       shift_state;
    logic       read_done;
    i2c_byte_t  tx_byte;
    logic       tx_bit;
    logic       sda_lvl;
    logic       sda_rel;
    i2c_byte_t  data_hi;
    i2c_byte_t  data_lo;

    assign slot_end  = (quarter == LAST_QTR);
    assign byte_done = (bit_cnt == 3'd7);
    assign read_done = (state == STOP) && slot_end;

    assign shift_state = (state == DEV_WR) || (state == REG_ADDR) || (state == DEV_RD) ||
                         (state == DATA_HI) || (state == DATA_LO);

    // Free running slot phase
    always_ff @(posedge PHASE1 or negedge reset_n) begin
        if (!reset_n) begin
            quarter <= '0;
        end else begin
            quarter <= quarter + quarter_t'(1);
        end
    end

    always_ff @(posedge PHASE1 or negedge reset_n) begin
        if (!reset_n) begin
            state   <= IDLE;
            bit_cnt <= 3'd0;
        end else if (slot_end) begin
            state <= next_state;
            if (shift_state) begin
                bit_cnt <= bit_cnt + 3'd1;  // Wraps back to 0 after bit 7
            end else begin
                bit_cnt <= 3'd0;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (enable) begin
                    next_state = START;
                end
            end
            START:     next_state = DEV_WR;
            DEV_WR: begin
                if (byte_done) begin
                    next_state = ACK0;
                end
            end
            ACK0:      next_state = REG_ADDR;
            REG_ADDR: begin
                if (byte_done) begin
                    next_state = ACK1;
                end
            end
            ACK1:      next_state = REP_START;
            REP_START: next_state = DEV_RD;
            DEV_RD: begin
                if (byte_done) begin
                    next_state = ACK2;
                end
            end
            ACK2:      next_state = DATA_HI;
            DATA_HI: begin
                if (byte_done) begin
                    next_state = ACK3;
                end
            end
            ACK3:      next_state = DATA_LO;
            DATA_LO: begin
                if (byte_done) begin
                    next_state = NACK;
                end
            end
            NACK:      next_state = STOP;
            STOP:      next_state = PAUSE;
            PAUSE: begin
                // Back-to-back reads skip the idle slot
                if (enable) begin
                    next_state = START;
                end else begin
                    next_state = IDLE;
                end
            end
            default:   next_state = IDLE;
        endcase
    end

    // Byte being shifted out, MSB first
    always_comb begin
        case (state)
            DEV_WR:   tx_byte = DEV_WRITE_BYTE;
            REG_ADDR: tx_byte = RAW_ANGLE_REG;
            default:  tx_byte = DEV_READ_BYTE;
        endcase
    end

    assign tx_bit = tx_byte[3'd7 - bit_cnt];

    // SCL/SDA pattern per state and quarter
    always_comb begin
        scl     = quarter[1];  // Low in q0 and q1, high in q2 and q3
        sda_lvl = 1'b1;
        sda_rel = 1'b0;
        case (state)
            START: begin
                // SDA falls while SCL is high
                scl     = (quarter != LAST_QTR);
                sda_lvl = (quarter == 2'd0);
            end
            DEV_WR, REG_ADDR, DEV_RD: begin
                sda_lvl = tx_bit;
            end
            ACK0, ACK1, ACK2, DATA_HI, DATA_LO, NACK: begin
                sda_rel = 1'b1;  // Target side owns SDA, NACK left high
            end
            ACK3: begin
                sda_lvl = 1'b0;  // Master ACK of high byte
            end
            REP_START: begin
                sda_lvl = (quarter == 2'd1) || (quarter == 2'd2);
            end
            STOP: begin
                // Rising SDA in q3 with SCL high
                sda_lvl = (quarter == 2'd0) || (quarter == LAST_QTR);
            end
            default: begin
                scl     = 1'b1;  // IDLE and PAUSE
                sda_rel = 1'b1;
            end
        endcase
    end

    // Open drain, only ever pulls low
    assign sda = (sda_rel || sda_lvl) ? 1'bz : 1'b0;

    always_ff @(posedge PHASE1) begin
        if (quarter == SAMPLE_QTR) begin
            if (state == DATA_HI) begin
                data_hi <= {data_hi[6:0], sda};
            end
            if (state == DATA_LO) begin
                data_lo <= {data_lo[6:0], sda};
            end
        end
    end

    always_ff @(posedge PHASE1 or negedge reset_n) begin
        if (!reset_n) begin
            sample.sample_strobe <= 1'b0;
            sample.sample_angle  <= '0;
        end else begin
            sample.sample_strobe <= read_done;  // First cycle of PAUSE
            if (read_done) begin
                sample.sample_angle <= {data_hi[3:0], data_lo};
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/motor_angle_pkg.sv
// ----------------------------------------------------------
// Motor angle loop shared definitions
// Angle and duty types, I2C bus states and loop constants
// ----------------------------------------------------------
`default_nettype none

package motor_angle_pkg;

    typedef logic [11:0]        angle_t;      // 0..4095 over one turn
    typedef logic [11:0]        duty_t;       // PWM compare value
    typedef logic signed [11:0] angle_err_t;  // Target minus measured, wrapped
    typedef logic [7:0]         i2c_byte_t;

    typedef struct packed {
        angle_t sample_angle;
        logic   sample_strobe;
    } angle_sample_t;

    typedef enum logic [3:0] {
        IDLE      = 4'h0,
        START     = 4'h1,
        DEV_WR    = 4'h2,
        ACK0      = 4'h3,
        REG_ADDR  = 4'h4,
        ACK1      = 4'h5,
        REP_START = 4'h6,
        DEV_RD    = 4'h7,
        ACK2      = 4'h8,
        DATA_HI   = 4'h9,
        ACK3      = 4'hA,
        DATA_LO   = 4'hB,
        NACK      = 4'hC,
        STOP      = 4'hD,
        PAUSE     = 4'hE
    } bus_state_t;

    // AS5600 addressing
    localparam i2c_byte_t DEV_WRITE_BYTE = 8'h6C;
    localparam i2c_byte_t DEV_READ_BYTE  = 8'h6D;
    localparam i2c_byte_t RAW_ANGLE_REG  = 8'h0C;

    localparam int QUARTERS_PER_BIT = 4;  // Clock cycles per bus slot
    typedef logic [$clog2(QUARTERS_PER_BIT)-1:0] quarter_t;

    localparam angle_t DEADBAND = 12'd8;
    localparam duty_t  DUTY_MAX = 12'd4095;

endpackage

`default_nettype wire

//--- hdl/motor_ctrl_top.sv
// ----------------------------------------------------------
// Motor position feedback top
// Encoder I2C reader feeding the angle PWM controller
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module motor_ctrl_top (
    input  logic                           PHASE1,
    input  logic                           reset_n,
    input  logic                           enable,
    input  motor_angle_pkg::angle_t        target_angle,
    output logic                           scl,
    inout  wire                            sda,
    output logic                           pwm_out,
    output logic                           dir,
    output motor_angle_pkg::angle_sample_t sample      // Last angle and read strobe
);

    // AS5600 bus master
    encoder_i2c_reader reader_i (
        .PHASE1  (PHASE1),
        .reset_n (reset_n),
        .enable  (enable),
        .scl     (scl),
        .sda     (sda),
        .sample  (sample)
    );

    angle_pwm_controller pwm_i (
        .PHASE1       (PHASE1),
        .reset_n      (reset_n),
        .sample       (sample),
        .target_angle (target_angle),
        .pwm_out      (pwm_out),
        .dir          (dir)
    );

endmodule

`default_nettype wire

//--- motor_ctrl_top.f
hdl/motor_angle_pkg.sv
hdl/encoder_i2c_reader.sv
hdl/angle_pwm_controller.sv
hdl/motor_ctrl_top.sv
bench/clock_gen.sv
bench/as5600_model.sv
bench/tb_motor_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the motor angle loop testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_motor_ctrl \
    -f motor_ctrl_top.f -o sim_motor_ctrl > build.log 2>&1 \
    || { cat build.log; echo "Build error"; exit 1; }

./obj_dir/sim_motor_ctrl > sim.log 2>&1
cat sim.log

grep -q "Simulation FAILED" sim.log && { echo "Run failed"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "Run ended without a pass"; exit 1; }
exit 0
